//--- all.f
+incdir+verification
hw/nestang_pkg.sv
hw/host_regs.sv
hw/autofire.sv
hw/pad_mapper.sv
hw/joypad_port.sv
hw/mem_scheduler.sv
hw/nestang_core.sv
verification/tb_nestang_core.sv

//--- Makefile
# Verilator build and run for the nestang core testbench

OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module tb_nestang_core -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_nestang_core 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_checks.svh
// ----------------------------------------------------------
// testbench checks
// typed compare tasks, per-test bookkeeping and counters
// ----------------------------------------------------------
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int    n_checks       = 0;
int    n_errors       = 0;
int    n_tests        = 0;
int    n_failed_tests = 0;
int    test_errors    = 0;
string cur_test       = "none";

task automatic report_error(input string msg);
  n_errors++;
  test_errors++;
  $display("ERROR in %s: %s", cur_test, msg);
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    test_errors++;
    $display("FAILED %s: %s expected %b actual %b", cur_test, name, exp, act);
  end
endtask

task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    test_errors++;
    $display("FAILED %s: %s expected %h actual %h", cur_test, name, exp, act);
  end
endtask

// memory address compare
task automatic check_addr(input string name,
                          input logic [nestang_pkg::MEM_ADDR_W-1:0] exp,
                          input logic [nestang_pkg::MEM_ADDR_W-1:0] act);
  n_checks++;
  if (act !== exp) begin
    n_errors++;
    test_errors++;
    $display("FAILED %s: %s expected %h actual %h", cur_test, name, exp, act);
  end
endtask

task automatic test_begin(input string name);
  cur_test    = name;
  test_errors = 0;
  n_tests++;
endtask

task automatic test_end();
  if (test_errors == 0) begin
    $display("test %s: pass", cur_test);
  end else begin
    n_failed_tests++;
    $display("test %s: fail with %0d errors", cur_test, test_errors);
  end
endtask

`endif

//--- verification/tb_nestang_core.sv
// ----------------------------------------------------------
// nestang core testbench
// host registers, loader stream, button mapping, joypad
// ports, autofire and memory scheduling
// ----------------------------------------------------------
`timescale 1ns/10ps

module tb_nestang_core;

  localparam int AUTOFIRE_PERIOD = 16;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  // cycle budget of each test
  localparam int REG_CYCLES  = 60;
  localparam int LOAD_CYCLES = 120;
  localparam int MAP_CYCLES  = 240;
  localparam int AUTO_CYCLES = 6 * AUTOFIRE_PERIOD + 40;
  localparam int MEM_CYCLES  = 140;
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + REG_CYCLES + LOAD_CYCLES +
                                        MAP_CYCLES + AUTO_CYCLES + MEM_CYCLES);

  logic        clk;
  logic        sys_resetn;
  logic        wb_cyc, wb_stb, wb_we;
  logic [7:0]  wb_adr, wb_dat_w, wb_dat_r;
  logic        wb_ack;
  logic [7:0]  loader_byte;
  logic        loader_byte_valid, loader_reset;
  logic [21:0] loader_addr;
  logic [7:0]  loader_wdata;
  logic        loader_write, loader_refresh, loader_done;
  logic [7:0]  ds1_rx0, ds1_rx1, ds2_rx0, ds2_rx1, usb1_btn, usb2_btn;
  logic        usb1_x, usb1_y, usb2_x, usb2_y;
  logic        nes_strobe;
  logic [1:0]  nes_joy_clk, joy_data;
  logic [7:0]  menu_btn;
  logic [21:0] nes_addr, mem_addr;
  logic        nes_cpu_read, nes_ppu_read, nes_write;
  logic [7:0]  nes_wdata, mem_wdata;
  logic        run_nes, mem_read_a, mem_read_b, mem_write, mem_refresh;

  logic [31:0] rng_state = 32'h3570_0033;
  logic [7:0]  got_bytes[$];   // loader bytes seen by the monitor
  logic        cmp_menu_en = 1'b0;
  logic [7:0]  exp_menu    = 8'h00;

  `include "tb_checks.svh"

  nestang_core #(.AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)) dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = xorshift32();
    return r[7:0];
  endfunction

  // expected NES byte from active-low DualShock bits
  function automatic logic [7:0] nes_btn_ref(input logic [7:0] ds0, input logic [7:0] ds1,
                                             input logic [7:0] usb, input logic [7:0] host,
                                             input logic turbo_b, input logic turbo_a);
    logic [7:0] b;
    b[7] = ~ds0[5];            // right
    b[6] = ~ds0[7];            // left
    b[5] = ~ds0[6];            // down
    b[4] = ~ds0[4];            // up
    b[3] = ~ds0[3];            // start
    b[2] = ~ds0[0];            // select
    b[1] = ~ds1[6] | turbo_b;  // cross is B
    b[0] = ~ds1[5] | turbo_a;  // circle is A
    return b | usb | host;
  endfunction

  // menu byte compared on the falling edge
  always @(negedge clk) begin
    if (cmp_menu_en)
      check_byte("menu_btn", exp_menu, menu_btn);
  end

  always @(negedge clk) begin
    if (sys_resetn && loader_byte_valid)
      got_bytes.push_back(loader_byte);
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // one classic cycle starting 1 ns after a rising edge
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [7:0] wdat,
                           output logic [7:0] rdat);
    int waits;
    waits    = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      tick(1);
      waits++;
    end while (!wb_ack && waits < 4);
    if (!wb_ack)
      report_error($sformatf("no ack for access to address %h", adr));
    else if (waits > 2)
      report_error($sformatf("ack for address %h took %0d cycles", adr, waits));
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read_check(input string name, input logic [7:0] adr,
                               input logic [7:0] exp);
    logic [7:0] rd;
    wb_access(1'b0, adr, 8'h00, rd);
    check_byte(name, exp, rd);
  endtask

  // strobe both ports, then shift eight bits out of each
  task automatic read_joypads(output logic [7:0] p1, output logic [7:0] p2);
    nes_strobe = 1'b1;
    tick(1);
    nes_strobe = 1'b0;
    for (int i = 0; i < 8; i++) begin
      p1[i] = joy_data[0];
      p2[i] = joy_data[1];
      nes_joy_clk = 2'b11;
      tick(1);
      nes_joy_clk = 2'b00;
      tick(1);
    end
  endtask

  task automatic sync_run_nes();
    int n;
    n = 0;
    while (!run_nes && n < 10) begin
      tick(1);
      n++;
    end
    if (!run_nes)
      report_error("run_nes never rose with loader_done high");
  endtask

  initial begin
    logic [7:0]  h1, h2, e1, e2, j1, j2, b;
    logic [7:0]  exp_q[$];
    logic [31:0] r;
    logic        seen_hi, seen_lo, bad;

    clk = 1'b0;
    sys_resetn = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 8'h00;
    wb_dat_w = 8'h00;
    loader_addr = '0;
    loader_wdata = 8'h00;
    loader_write = 1'b0;
    loader_refresh = 1'b0;
    loader_done = 1'b0;
    ds1_rx0 = 8'hff;
    ds1_rx1 = 8'hff;
    ds2_rx0 = 8'hff;
    ds2_rx1 = 8'hff;
    usb1_btn = 8'h00;
    usb2_btn = 8'h00;
    usb1_x = 1'b0;
    usb1_y = 1'b0;
    usb2_x = 1'b0;
    usb2_y = 1'b0;
    nes_strobe = 1'b0;
    nes_joy_clk = 2'b00;
    nes_addr = '0;
    nes_cpu_read = 1'b0;
    nes_ppu_read = 1'b0;
    nes_write = 1'b0;
    nes_wdata = 8'h00;

    test_begin("reset");
    tick(RESET_CYCLES);
    check_bit("loader_reset in reset", 1'b1, loader_reset);
    check_bit("wb_ack in reset", 1'b0, wb_ack);
    check_bit("run_nes in reset", 1'b0, run_nes);
    check_byte("joy_data in reset", 8'h00, {6'b0, joy_data});
    sys_resetn = 1'b1;
    tick(2);
    check_bit("loader_reset after reset", 1'b0, loader_reset);
    test_end();

    test_begin("register access");
    h1 = rand_byte();
    h2 = rand_byte();
    wb_write(nestang_pkg::REG_LOADER_CONF, 8'h01);
    wb_write(nestang_pkg::REG_BTN_P1, h1);
    wb_write(nestang_pkg::REG_BTN_P2, h2);
    wb_read_check("loader conf", nestang_pkg::REG_LOADER_CONF, 8'h01);
    wb_read_check("button p1", nestang_pkg::REG_BTN_P1, h1);
    wb_read_check("button p2", nestang_pkg::REG_BTN_P2, h2);
    check_bit("loader_reset set", 1'b1, loader_reset);
    wb_write(nestang_pkg::REG_LOADER_CONF, 8'h00);
    tick(2);
    check_bit("loader_reset cleared", 1'b0, loader_reset);
    test_end();

    test_begin("loader stream");
    got_bytes.delete();
    for (int i = 0; i < 20; i++) begin
      b = rand_byte();
      exp_q.push_back(b);
      wb_write(nestang_pkg::REG_LOADER_DATA, b);
    end
    tick(2);
    if (got_bytes.size() != 20)
      report_error($sformatf("%0d loader pulses for 20 writes", got_bytes.size()));
    else
      for (int i = 0; i < 20; i++)
        check_byte($sformatf("loader byte %0d", i), exp_q[i], got_bytes[i]);
    wb_read_check("data port read", nestang_pkg::REG_LOADER_DATA, 8'h00);
    test_end();

    test_begin("button mapping");
    for (int round = 0; round < 4; round++) begin
      cmp_menu_en = 1'b0;
      h1 = rand_byte();
      h2 = rand_byte();
      wb_write(nestang_pkg::REG_BTN_P1, h1);
      wb_write(nestang_pkg::REG_BTN_P2, h2);
      ds1_rx0 = rand_byte();
      ds1_rx1 = rand_byte() | 8'h90;  // square and triangle released
      ds2_rx0 = rand_byte();
      ds2_rx1 = rand_byte() | 8'h90;
      usb1_btn = rand_byte();
      usb2_btn = rand_byte();
      e1 = nes_btn_ref(ds1_rx0, ds1_rx1, usb1_btn, h1, 1'b0, 1'b0);
      e2 = nes_btn_ref(ds2_rx0, ds2_rx1, usb2_btn, h2, 1'b0, 1'b0);
      exp_menu = e1 | e2;
      cmp_menu_en = 1'b1;
      read_joypads(j1, j2);
      check_byte("joypad 1 bits", e1, j1);
      check_byte("joypad 2 bits", e2, j2);
      check_bit("joypad 1 zero fill", 1'b0, joy_data[0]);
      check_bit("joypad 2 zero fill", 1'b0, joy_data[1]);
    end
    cmp_menu_en = 1'b0;
    test_end();

    test_begin("autofire");
    wb_write(nestang_pkg::REG_BTN_P1, 8'h00);
    wb_write(nestang_pkg::REG_BTN_P2, 8'h00);
    ds1_rx0 = 8'hff;
    ds2_rx0 = 8'hff;
    ds2_rx1 = 8'hff;
    usb1_btn = 8'h00;
    usb2_btn = 8'h00;
    ds1_rx1 = 8'h7f;                   // square held
    seen_hi = 1'b0;
    seen_lo = 1'b0;
    for (int i = 0; i < 4 * AUTOFIRE_PERIOD; i++) begin
      tick(1);
      if (menu_btn[1]) seen_hi = 1'b1;
      else             seen_lo = 1'b1;
    end
    check_bit("B seen high", 1'b1, seen_hi);
    check_bit("B seen low", 1'b1, seen_lo);
    ds1_rx1 = 8'hff;
    tick(2);
    bad = 1'b0;
    for (int i = 0; i < 2 * AUTOFIRE_PERIOD; i++) begin
      bad = bad | menu_btn[1];
      tick(1);
    end
    check_bit("B after release", 1'b0, bad);
    test_end();

    test_begin("memory scheduling");
    nes_cpu_read = 1'b1;
    nes_ppu_read = 1'b1;
    nes_write = 1'b1;
    bad = 1'b0;
    for (int i = 0; i < 15; i++) begin
      tick(1);
      bad = bad | run_nes | mem_read_a | mem_read_b | mem_write | mem_refresh;
    end
    check_bit("NES traffic while loading", 1'b0, bad);
    nes_write = 1'b0;
    r = xorshift32();
    nes_addr = r[21:0];
    loader_done = 1'b1;
    sync_run_nes();
    // run_nes seen at step 0, memory slot one cycle later
    for (int i = 1; i <= 30; i++) begin
      tick(1);
      check_bit("run_nes period", (i % 5 == 0), run_nes);
      check_bit("mem_read_a after run_nes", (i % 5 == 1), mem_read_a);
      check_bit("mem_read_b after run_nes", (i % 5 == 1), mem_read_b);
      check_bit("no refresh with reads pending", 1'b0, mem_refresh);
      if (i % 5 == 1)
        check_addr("read address", nes_addr, mem_addr);
    end
    nes_cpu_read = 1'b0;
    nes_ppu_read = 1'b0;
    for (int i = 0; i < 5; i++) begin
      r = xorshift32();
      loader_addr  = r[29:8];
      loader_wdata = r[7:0];
      loader_write = 1'b1;
      #1;
      check_bit("loader mem_write", 1'b1, mem_write);
      check_addr("loader address", loader_addr, mem_addr);
      check_byte("loader data", loader_wdata, mem_wdata);
      check_bit("no refresh under write", 1'b0, mem_refresh);
      tick(1);
    end
    loader_write = 1'b0;
    sync_run_nes();
    for (int i = 1; i <= 15; i++) begin
      tick(1);
      check_bit("idle refresh", (i % 5 == 1), mem_refresh);
    end
    test_end();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed_tests, n_checks, n_errors);
    if (n_errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- hw/nestang_core.sv
// ----------------------------------------------------------
// nestang core
// console glue: host registers, controller mapping and
// joypad ports for two players, memory scheduling
// ----------------------------------------------------------
`timescale 1ns/10ps

module nestang_core #(
  parameter int AUTOFIRE_PERIOD = 16
) (
  input  logic                               clk,
  input  logic                               sys_resetn,
  // host bus
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [7:0]                         wb_adr,
  input  logic [7:0]                         wb_dat_w,
  output logic [7:0]                         wb_dat_r,
  output logic                               wb_ack,
  // game loader
  output logic [7:0]                         loader_byte,
  output logic                               loader_byte_valid,
  output logic                               loader_reset,
  input  logic [nestang_pkg::MEM_ADDR_W-1:0] loader_addr,
  input  logic [7:0]                         loader_wdata,
  input  logic                               loader_write,
  input  logic                               loader_refresh,
  input  logic                               loader_done,
  // controllers
  input  logic [7:0]                         ds1_rx0,
  input  logic [7:0]                         ds1_rx1,
  input  logic [7:0]                         ds2_rx0,
  input  logic [7:0]                         ds2_rx1,
  input  logic [7:0]                         usb1_btn,
  input  logic                               usb1_x,
  input  logic                               usb1_y,
  input  logic [7:0]                         usb2_btn,
  input  logic                               usb2_x,
  input  logic                               usb2_y,
  input  logic                               nes_strobe,
  input  logic [1:0]                         nes_joy_clk,
  output logic [1:0]                         joy_data,
  output logic [7:0]                         menu_btn,
  // NES and memory controller
  input  logic [nestang_pkg::MEM_ADDR_W-1:0] nes_addr,
  input  logic                               nes_cpu_read,
  input  logic                               nes_ppu_read,
  input  logic                               nes_write,
  input  logic [7:0]                         nes_wdata,
  output logic                               run_nes,
  output logic                               mem_read_a,
  output logic                               mem_read_b,
  output logic                               mem_write,
  output logic                               mem_refresh,
  output logic [nestang_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]                         mem_wdata
);

  logic [7:0] host_btn1;
  logic [7:0] host_btn2;
  logic [7:0] nes_btn1;
  logic [7:0] nes_btn2;

  host_regs host_regs_i (
    .clk(clk), .sys_resetn(sys_resetn),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .loader_conf(),                       // only bit 0 is used, inside
    .host_btn1(host_btn1), .host_btn2(host_btn2),
    .loader_byte(loader_byte), .loader_byte_valid(loader_byte_valid),
    .loader_reset(loader_reset)
  );

  pad_mapper #(.AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)) pad1_i (
    .clk(clk), .sys_resetn(sys_resetn), .ds_rx0(ds1_rx0), .ds_rx1(ds1_rx1),
    .usb_btn(usb1_btn), .usb_x(usb1_x), .usb_y(usb1_y),
    .host_btn(host_btn1), .nes_btn(nes_btn1)
  );

  pad_mapper #(.AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)) pad2_i (
    .clk(clk), .sys_resetn(sys_resetn), .ds_rx0(ds2_rx0), .ds_rx1(ds2_rx1),
    .usb_btn(usb2_btn), .usb_x(usb2_x), .usb_y(usb2_y),
    .host_btn(host_btn2), .nes_btn(nes_btn2)
  );

  joypad_port joy1_i (
    .clk(clk), .sys_resetn(sys_resetn), .nes_btn(nes_btn1),
    .strobe(nes_strobe), .joy_clk(nes_joy_clk[0]), .data(joy_data[0])
  );

  joypad_port joy2_i (
    .clk(clk), .sys_resetn(sys_resetn), .nes_btn(nes_btn2),
    .strobe(nes_strobe), .joy_clk(nes_joy_clk[1]), .data(joy_data[1])
  );

  assign menu_btn = nes_btn1 | nes_btn2;  // either player drives the SD menu

  mem_scheduler mem_sched_i (
    .clk(clk), .sys_resetn(sys_resetn), .loader_done(loader_done),
    .nes_addr(nes_addr), .nes_cpu_read(nes_cpu_read), .nes_ppu_read(nes_ppu_read),
    .nes_write(nes_write), .nes_wdata(nes_wdata),
    .loader_addr(loader_addr), .loader_wdata(loader_wdata),
    .loader_write(loader_write), .loader_refresh(loader_refresh),
    .run_nes(run_nes), .mem_read_a(mem_read_a), .mem_read_b(mem_read_b),
    .mem_write(mem_write), .mem_refresh(mem_refresh),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

endmodule

//--- hw/mem_scheduler.sv
// ----------------------------------------------------------
// memory scheduler
// five-phase clock-enable cycle for the NES and the memory
// controller, merges loader and NES commands into one set
// ----------------------------------------------------------
`timescale 1ns/10ps

module mem_scheduler (
  input  logic                               clk,
  input  logic                               sys_resetn,
  input  logic                               loader_done,
  input  logic [nestang_pkg::MEM_ADDR_W-1:0] nes_addr,
  input  logic                               nes_cpu_read,
  input  logic                               nes_ppu_read,
  input  logic                               nes_write,
  input  logic [7:0]                         nes_wdata,
  input  logic [nestang_pkg::MEM_ADDR_W-1:0] loader_addr,
  input  logic [7:0]                         loader_wdata,
  input  logic                               loader_write,
  input  logic                               loader_refresh,
  output logic                               run_nes,
  output logic                               mem_read_a,
  output logic                               mem_read_b,
  output logic                               mem_write,
  output logic                               mem_refresh,
  output logic [nestang_pkg::MEM_ADDR_W-1:0] mem_addr,
  output logic [7:0]                         mem_wdata
);

  logic [nestang_pkg::PHASE_W-1:0] phase;
  logic                            run_mem;
  logic                            nes_idle;

  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase <= '0;
    else if (phase == nestang_pkg::NES_CE_LAST)
      phase <= '0;
    else
      phase <= phase + 1'b1;
  end

  // NES steps on phase 4 and its command is taken on the next phase 0
  assign run_mem = (phase == nestang_pkg::PHASE_RUN_MEM) & loader_done;
  assign run_nes = (phase == nestang_pkg::PHASE_RUN_NES) & loader_done;

  assign nes_idle = ~nes_cpu_read & ~nes_ppu_read & ~nes_write;

  assign mem_read_a = nes_cpu_read & run_mem;
  assign mem_read_b = nes_ppu_read & run_mem;
  assign mem_write  = (nes_write & run_mem) | loader_write;

  // idle memory slot or a refresh asked for by the loader
  assign mem_refresh = (nes_idle & ~loader_write & run_mem) |
                       (loader_refresh & ~loader_write);

  // loader owns address and data whenever it writes
  assign mem_addr  = loader_write ? loader_addr  : nes_addr;
  assign mem_wdata = loader_write ? loader_wdata : nes_wdata;

  phase_in_range: assert property (@(posedge clk) disable iff (!sys_resetn)
    phase <= nestang_pkg::NES_CE_LAST);

  write_refresh_excl: assert property (@(posedge clk) disable iff (!sys_resetn)
    !(mem_write && mem_refresh));

endmodule

//--- hw/joypad_port.sv
// ----------------------------------------------------------
// joypad port
// NES controller shift register, parallel load on strobe,
// shift right on the falling edge of the port clock
// ----------------------------------------------------------
`timescale 1ns/10ps

module joypad_port (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] nes_btn,
  input  logic       strobe,
  input  logic       joy_clk,
  output logic       data
);

  logic [7:0] shift_q;
  logic       joy_clk_q;   // port clock level from last cycle
  logic       joy_fall;

  assign joy_fall = joy_clk_q & ~joy_clk;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q   <= 8'h00;
      joy_clk_q <= 1'b0;
    end else begin
      joy_clk_q <= joy_clk;
      // a shift in the same cycle as strobe takes priority
      if (joy_fall)
        shift_q <= {1'b0, shift_q[7:1]};
      else if (strobe)
        shift_q <= nes_btn;
    end
  end

  assign data = shift_q[0];   // A first, then B, select, start...

endmodule

//--- hw/pad_mapper.sv
// ----------------------------------------------------------
// pad mapper
// one player's DualShock and USB gamepad state to an NES
// button byte, turbo on square (B) and triangle (A)
// ----------------------------------------------------------
`timescale 1ns/10ps

module pad_mapper #(
  parameter int AUTOFIRE_PERIOD = 16
) (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic [7:0] ds_rx0,     // active low
  input  logic [7:0] ds_rx1,     // active low
  input  logic [7:0] usb_btn,    // already in NES order
  input  logic       usb_x,
  input  logic       usb_y,
  input  logic [7:0] host_btn,
  output logic [7:0] nes_btn
);

  logic       turbo_b;
  logic       turbo_a;
  logic [7:0] ds_btn;

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) af_b_i (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .btn       (~ds_rx1[nestang_pkg::DS_SQUARE] | usb_y),
    .turbo     (turbo_b)
  );

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) af_a_i (
    .clk       (clk),
    .sys_resetn(sys_resetn),
    .btn       (~ds_rx1[nestang_pkg::DS_TRIANGLE] | usb_x),
    .turbo     (turbo_a)
  );

  // cross is B, circle is A
  always_comb begin
    ds_btn = 8'h00;
    ds_btn[nestang_pkg::BTN_RIGHT]  = ~ds_rx0[nestang_pkg::DS_RIGHT];
    ds_btn[nestang_pkg::BTN_LEFT]   = ~ds_rx0[nestang_pkg::DS_LEFT];
    ds_btn[nestang_pkg::BTN_DOWN]   = ~ds_rx0[nestang_pkg::DS_DOWN];
    ds_btn[nestang_pkg::BTN_UP]     = ~ds_rx0[nestang_pkg::DS_UP];
    ds_btn[nestang_pkg::BTN_START]  = ~ds_rx0[nestang_pkg::DS_START];
    ds_btn[nestang_pkg::BTN_SELECT] = ~ds_rx0[nestang_pkg::DS_SELECT];
    ds_btn[nestang_pkg::BTN_B]      = ~ds_rx1[nestang_pkg::DS_CROSS] | turbo_b;
    ds_btn[nestang_pkg::BTN_A]      = ~ds_rx1[nestang_pkg::DS_CIRCLE] | turbo_a;
  end

  assign nes_btn = ds_btn | usb_btn | host_btn;

endmodule

//--- hw/autofire.sv
// ----------------------------------------------------------
// autofire
// toggles the turbo output every AUTOFIRE_PERIOD cycles
// while the button is held
// ----------------------------------------------------------
`timescale 1ns/10ps

module autofire #(
  parameter int AUTOFIRE_PERIOD = 16
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic turbo
);

  localparam int CNT_W = (AUTOFIRE_PERIOD > 1) ? $clog2(AUTOFIRE_PERIOD) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AUTOFIRE_PERIOD - 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!sys_resetn || !btn) begin  // released button restarts the burst
      cnt   <= '0;
      turbo <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt   <= '0;
      turbo <= ~turbo;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- hw/host_regs.sv
// ----------------------------------------------------------
// host register port
// wishbone classic slave with loader config, injected
// buttons and the ROM byte stream for the game loader
// ----------------------------------------------------------
`timescale 1ns/10ps

module host_regs (
  input  logic       clk,
  input  logic       sys_resetn,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic [7:0] wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  output logic [7:0] loader_conf,
  output logic [7:0] host_btn1,
  output logic [7:0] host_btn2,
  output logic [7:0] loader_byte,
  output logic       loader_byte_valid,
  output logic       loader_reset
);

  logic       wb_req;     // new access not yet acked
  logic       wr_data;
  logic [7:0] rd_mux;

  assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
  assign wr_data = wb_req & wb_we & (wb_adr == nestang_pkg::REG_LOADER_DATA);

  always_comb begin
    case (wb_adr)
      nestang_pkg::REG_LOADER_CONF: rd_mux = loader_conf;
      nestang_pkg::REG_BTN_P1:      rd_mux = host_btn1;
      nestang_pkg::REG_BTN_P2:      rd_mux = host_btn2;
      default:                      rd_mux = 8'h00; // data port reads back 0
    endcase
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      wb_ack            <= 1'b0;
      loader_byte_valid <= 1'b0;
      loader_reset      <= 1'b1;
      loader_conf       <= 8'h00;
      host_btn1         <= 8'h00;
      host_btn2         <= 8'h00;
    end else begin
      wb_ack            <= wb_req;   // drops for a cycle between accesses
      loader_byte_valid <= wr_data;
      loader_reset      <= loader_conf[0];
      if (wb_req && wb_we) begin
        case (wb_adr)
          nestang_pkg::REG_LOADER_CONF: loader_conf <= wb_dat_w;
          nestang_pkg::REG_BTN_P1:      host_btn1   <= wb_dat_w;
          nestang_pkg::REG_BTN_P2:      host_btn2   <= wb_dat_w;
          default: ;
        endcase
      end
    end
  end

  // read data and loader byte registers
  always_ff @(posedge clk) begin
    if (wb_req && !wb_we)
      wb_dat_r <= rd_mux;
    if (wr_data)
      loader_byte <= wb_dat_w;
  end

  ack_single_cycle: assert property (@(posedge clk) disable iff (!sys_resetn)
    wb_ack |=> !wb_ack);

endmodule

//--- hw/nestang_pkg.sv
// ----------------------------------------------------------
// nestang package
// host register map, clock-enable phases, memory width and
// the NES and DualShock button bit positions
// ----------------------------------------------------------
package nestang_pkg;

  // host register map
  localparam logic [7:0] REG_LOADER_CONF = 8'h35; // bit 0 holds the loader in reset
  localparam logic [7:0] REG_LOADER_DATA = 8'h37; // one ROM byte per write
  localparam logic [7:0] REG_BTN_P1      = 8'h40;
  localparam logic [7:0] REG_BTN_P2      = 8'h41;

  localparam int MEM_ADDR_W = 22;                 // 4 MB space

  // five-phase clock-enable cycle
  localparam int              PHASE_W       = 3;
  localparam logic [PHASE_W-1:0] NES_CE_LAST   = 3'd4;
  localparam logic [PHASE_W-1:0] PHASE_RUN_MEM = 3'd0;
  localparam logic [PHASE_W-1:0] PHASE_RUN_NES = 3'd4;

  // NES button byte, A at bit 0
  localparam logic [2:0] BTN_A      = 3'd0;
  localparam logic [2:0] BTN_B      = 3'd1;
  localparam logic [2:0] BTN_SELECT = 3'd2;
  localparam logic [2:0] BTN_START  = 3'd3;
  localparam logic [2:0] BTN_UP     = 3'd4;
  localparam logic [2:0] BTN_DOWN   = 3'd5;
  localparam logic [2:0] BTN_LEFT   = 3'd6;
  localparam logic [2:0] BTN_RIGHT  = 3'd7;

  // DualShock receive byte 0 (active low)
  localparam logic [2:0] DS_SELECT = 3'd0;
  localparam logic [2:0] DS_START  = 3'd3;
  localparam logic [2:0] DS_UP     = 3'd4;
  localparam logic [2:0] DS_RIGHT  = 3'd5;
  localparam logic [2:0] DS_DOWN   = 3'd6;
  localparam logic [2:0] DS_LEFT   = 3'd7;

  // DualShock receive byte 1 (active low)
  localparam logic [2:0] DS_TRIANGLE = 3'd4;
  localparam logic [2:0] DS_CIRCLE   = 3'd5;
  localparam logic [2:0] DS_CROSS    = 3'd6;
  localparam logic [2:0] DS_SQUARE   = 3'd7;

endpackage
